// File: verilog/uniboard_pkg.sv
// shared bus types and framing constants; uart is 8n1 at a fixed 12 clocks per bit
package uniboard_pkg;
	// uart bit timing
	localparam int clks_per_bit = 12;
	localparam int bit_cnt_w = $clog2(clks_per_bit);

	// framing bytes
	localparam logic [7:0] byte_start = 8'h01;
	localparam logic [7:0] byte_end = 8'h17;
	localparam logic [7:0] byte_escape = 8'h1B;

	// periph byte, register address, four write data bytes
	localparam int payload_max = 6;
	localparam int payload_cnt_w = $clog2(payload_max + 1);

	// pwm count advances once every pwm_tick_div clocks
	localparam int pwm_tick_div = 47;
	localparam int pwm_div_w = $clog2(pwm_tick_div);
	localparam int pwm_periph_id = 2;
	localparam logic [7:0] reg_left_duty = 8'd0;
	localparam logic [7:0] reg_right_duty = 8'd1;

	typedef enum logic {
		op_write = 1'b0,
		op_read = 1'b1
	} bus_op_e;

	// decoded frame, write data already zero filled
	typedef struct packed {
		logic read;
		logic [6:0] periph;
		logic [7:0] addr;
		logic [31:0] wdata;
	} command_t;

	// broadcast to every peripheral, qualified by its select bit
	typedef struct packed {
		bus_op_e op;
		logic [7:0] addr;
		logic [31:0] wdata;
	} bus_req_t;

	// size in bytes, sets how many data bytes the reply carries
	typedef struct packed {
		logic [31:0] rdata;
		logic [2:0] size;
	} bus_rsp_t;

	typedef struct packed {
		logic [7:0] periph_byte;
		logic [7:0] addr;
		logic [31:0] rdata;
		logic [2:0] size;
	} reply_t;
endpackage

// File: verilog/uart_rx.sv
// 8n1 only, no parity; a byte whose stop bit reads low is silently dropped
module uart_rx
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic rx,
	output logic [7:0] data,
	output logic data_valid
);
	typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} rx_state_e;

	rx_state_e state;
	logic rx_meta;
	logic rx_sync;
	logic [bit_cnt_w-1:0] count;
	logic [2:0] bit_idx;
	logic [7:0] shift;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= st_idle;
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			data_valid <= 1'b0;
		end
		else
		begin
			// two flop synchroniser, line idles high
			rx_meta <= rx;
			rx_sync <= rx_meta;
			data_valid <= 1'b0;
			case (state)
				st_idle:
				begin
					count <= '0;
					if (!rx_sync)
						state <= st_start;
				end
				st_start:
				begin
					// half a bit in, start bit should still be low
					if (count == bit_cnt_w'(clks_per_bit / 2 - 1))
					begin
						count <= '0;
						bit_idx <= '0;
						state <= rx_sync ? st_idle : st_data;
					end
					else
						count <= count + 1'b1;
				end
				st_data:
				begin
					if (count == bit_cnt_w'(clks_per_bit - 1))
					begin
						count <= '0;
						// lsb arrives first
						shift <= {rx_sync, shift[7:1]};
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= st_stop;
					end
					else
						count <= count + 1'b1;
				end
				default:
				begin
					if (count == bit_cnt_w'(clks_per_bit - 1))
					begin
						// framing error check
						if (rx_sync)
						begin
							data <= shift;
							data_valid <= 1'b1;
						end
						state <= st_idle;
					end
					else
						count <= count + 1'b1;
				end
			endcase
		end
	end
endmodule

// File: verilog/uart_tx.sv
// 8n1 only; send is ignored while busy, hold it until busy is seen
module uart_tx
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic [7:0] data,
	input logic send,
	output logic busy,
	output logic tx
);
	logic [bit_cnt_w-1:0] count;
	logic [3:0] bit_idx;
	// data bits then the stop bit
	logic [8:0] shift;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			tx <= 1'b1;
			count <= '0;
			bit_idx <= '0;
		end
		else if (!busy)
		begin
			tx <= 1'b1;
			if (send)
			begin
				// start bit goes out right away
				shift <= {1'b1, data};
				tx <= 1'b0;
				busy <= 1'b1;
				count <= '0;
				bit_idx <= '0;
			end
		end
		else if (count == bit_cnt_w'(clks_per_bit - 1))
		begin
			count <= '0;
			// stop bit finished
			if (bit_idx == 4'd9)
				busy <= 1'b0;
			else
			begin
				tx <= shift[0];
				shift <= {1'b1, shift[8:1]};
				bit_idx <= bit_idx + 4'd1;
			end
		end
		else
			count <= count + 1'b1;
	end
endmodule

// File: verilog/frame_decoder.sv
// bytes arriving while a command awaits its handshake are dropped, frames included
module frame_decoder
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic [7:0] data,
	input logic data_valid,
	output command_t cmd,
	output logic cmd_req,
	input logic cmd_ack
);
	typedef enum logic [1:0] {st_idle, st_frame, st_escaped, st_hold} dec_state_e;

	dec_state_e state;
	logic [7:0] buffer [payload_max];
	logic [payload_cnt_w-1:0] count;
	logic [31:0] write_data;

	// missing write bytes read as zero
	always_comb
	begin
		for (int i = 0; i < 4; i++)
			write_data[8*i +: 8] = (count > payload_cnt_w'(i + 2)) ? buffer[i + 2] : 8'h00;
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= st_idle;
			count <= '0;
			cmd_req <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					count <= '0;
					if (data_valid && data == byte_start)
						state <= st_frame;
				end
				st_frame:
				begin
					if (data_valid)
					begin
						case (data)
							// restart, previous bytes thrown away
							byte_start:
								count <= '0;
							byte_escape:
								state <= st_escaped;
							byte_end:
							begin
								// need at least periph and address
								if (count >= payload_cnt_w'(2))
								begin
									cmd.read <= buffer[0][7];
									cmd.periph <= buffer[0][6:0];
									cmd.addr <= buffer[1];
									cmd.wdata <= write_data;
									cmd_req <= 1'b1;
									state <= st_hold;
								end
								else
									state <= st_idle;
							end
							default:
							begin
								// extra bytes ignored
								if (count < payload_cnt_w'(payload_max))
								begin
									buffer[count] <= data;
									count <= count + 1'b1;
								end
							end
						endcase
					end
				end
				st_escaped:
				begin
					// taken literally, even framing bytes
					if (data_valid)
					begin
						if (count < payload_cnt_w'(payload_max))
						begin
							buffer[count] <= data;
							count <= count + 1'b1;
						end
						state <= st_frame;
					end
				end
				default:
				begin
					if (cmd_req && cmd_ack)
						cmd_req <= 1'b0;
					if (!cmd_req && !cmd_ack)
						state <= st_idle;
				end
			endcase
		end
	end
endmodule

// File: verilog/bus_sequencer.sv
// one command at a time; no new command is taken until the reply handshake closes
module bus_sequencer
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input command_t cmd,
	input logic cmd_req,
	output logic cmd_ack,
	output bus_req_t bus_req,
	output logic [127:0] select,
	input bus_rsp_t bus_rsp,
	output reply_t reply,
	output logic reply_req,
	input logic reply_ack
);
	typedef enum logic [3:0] {
		st_idle, st_wr_select, st_wr_hold, st_gap, st_rd_setup,
		st_rd_select, st_rd_hold, st_capture, st_reply
	} seq_state_e;

	seq_state_e state;
	command_t active;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= st_idle;
			cmd_ack <= 1'b0;
			select <= '0;
			reply_req <= 1'b0;
		end
		else
		begin
			// ack falls once the decoder lets go of req
			if (cmd_ack && !cmd_req)
				cmd_ack <= 1'b0;
			case (state)
				st_idle:
				begin
					if (cmd_req && !cmd_ack)
					begin
						// bus setup cycle
						active <= cmd;
						cmd_ack <= 1'b1;
						bus_req.op <= cmd.read ? op_read : op_write;
						bus_req.addr <= cmd.addr;
						bus_req.wdata <= cmd.wdata;
						state <= cmd.read ? st_rd_select : st_wr_select;
					end
				end
				st_wr_select:
				begin
					select <= 128'(1) << active.periph;
					state <= st_wr_hold;
				end
				// second select cycle of the write
				st_wr_hold:
					state <= st_gap;
				st_gap:
				begin
					select <= '0;
					state <= st_rd_setup;
				end
				// read back of the same register
				st_rd_setup:
				begin
					bus_req.op <= op_read;
					state <= st_rd_select;
				end
				st_rd_select:
				begin
					select <= 128'(1) << active.periph;
					state <= st_rd_hold;
				end
				st_rd_hold:
					state <= st_capture;
				st_capture:
				begin
					// sampled at the end of the second select cycle
					reply.periph_byte <= {active.read, active.periph};
					reply.addr <= active.addr;
					reply.rdata <= bus_rsp.rdata;
					reply.size <= bus_rsp.size;
					select <= '0;
					reply_req <= 1'b1;
					state <= st_reply;
				end
				default:
				begin
					if (reply_req && reply_ack)
						reply_req <= 1'b0;
					if (!reply_req && !reply_ack)
						state <= st_idle;
				end
			endcase
		end
	end
endmodule

// File: verilog/reply_encoder.sv
// data bytes beyond the fourth repeat, so peripherals must report a size of 4 or less
module reply_encoder
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input reply_t reply,
	input logic reply_req,
	output logic reply_ack,
	output logic [7:0] tx_data,
	output logic send,
	input logic busy
);
	typedef enum logic [2:0] {st_idle, st_load, st_send, st_wait, st_done} enc_state_e;

	enc_state_e state;
	reply_t held;
	logic [3:0] idx;
	logic [3:0] end_idx;
	logic [1:0] data_sel;
	logic [7:0] cur_byte;
	logic frame_byte;
	logic needs_escape;
	logic escape_sent;
	logic last;

	// start, two header bytes, then size data bytes
	assign end_idx = 4'd3 + {1'b0, held.size};
	assign data_sel = 2'(idx - 4'd3);

	always_comb
	begin
		frame_byte = 1'b0;
		case (idx)
			4'd1: cur_byte = held.periph_byte;
			4'd2: cur_byte = held.addr;
			default: cur_byte = held.rdata[8*data_sel +: 8];
		endcase
		if (idx == 4'd0)
		begin
			cur_byte = byte_start;
			frame_byte = 1'b1;
		end
		else if (idx == end_idx)
		begin
			cur_byte = byte_end;
			frame_byte = 1'b1;
		end
		// framing bytes themselves go out raw
		needs_escape = !frame_byte &&
			(cur_byte == byte_start || cur_byte == byte_end || cur_byte == byte_escape);
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= st_idle;
			reply_ack <= 1'b0;
			send <= 1'b0;
			escape_sent <= 1'b0;
			last <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (reply_req)
					begin
						held <= reply;
						reply_ack <= 1'b1;
						idx <= '0;
						escape_sent <= 1'b0;
						last <= 1'b0;
						state <= st_load;
					end
				end
				st_load:
				begin
					send <= 1'b1;
					state <= st_send;
					// escape first, same index again afterwards
					if (needs_escape && !escape_sent)
					begin
						tx_data <= byte_escape;
						escape_sent <= 1'b1;
					end
					else
					begin
						tx_data <= cur_byte;
						escape_sent <= 1'b0;
						last <= (idx == end_idx);
						idx <= idx + 4'd1;
					end
				end
				st_send:
				begin
					if (busy)
					begin
						send <= 1'b0;
						state <= st_wait;
					end
				end
				// character still on the line
				st_wait:
				begin
					if (!busy)
						state <= last ? st_done : st_load;
				end
				default:
				begin
					if (!reply_req)
					begin
						reply_ack <= 1'b0;
						state <= st_idle;
					end
				end
			endcase
		end
	end
endmodule

// File: verilog/motor_pwm_peripheral.sv
// pwm period is 256 ticks of 47 clocks; duty 255 still leaves one low tick per period
module motor_pwm_peripheral
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input bus_req_t bus_req,
	input logic select,
	output bus_rsp_t bus_rsp,
	output logic pwm_left,
	output logic pwm_right
);
	logic [7:0] duty_left;
	logic [7:0] duty_right;
	logic select_q;
	logic [pwm_div_w-1:0] div_count;
	logic [7:0] pwm_count;

	// registers and write on the rising edge of select
	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			duty_left <= '0;
			duty_right <= '0;
			select_q <= 1'b0;
		end
		else
		begin
			select_q <= select;
			if (select && !select_q && bus_req.op == op_write)
			begin
				if (bus_req.addr == reg_left_duty)
					duty_left <= bus_req.wdata[7:0];
				else if (bus_req.addr == reg_right_duty)
					duty_right <= bus_req.wdata[7:0];
			end
		end
	end

	// read data settles one cycle into select, both registers one byte
	always_ff @(posedge clk_12MHz)
	begin
		if (select)
		begin
			bus_rsp.size <= 3'd1;
			case (bus_req.addr)
				reg_left_duty: bus_rsp.rdata <= {24'd0, duty_left};
				reg_right_duty: bus_rsp.rdata <= {24'd0, duty_right};
				default: bus_rsp.rdata <= '0;
			endcase
		end
	end

	// tick divider and free running count
	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			div_count <= '0;
			pwm_count <= '0;
			pwm_left <= 1'b0;
			pwm_right <= 1'b0;
		end
		else
		begin
			if (div_count == pwm_div_w'(pwm_tick_div - 1))
			begin
				div_count <= '0;
				pwm_count <= pwm_count + 8'd1;
			end
			else
				div_count <= div_count + 1'b1;
			pwm_left <= (pwm_count < duty_left);
			pwm_right <= (pwm_count < duty_right);
		end
	end
endmodule

// File: verilog/uniboard_top.sv
// reset is external and synchronous to clk_12MHz; only the motor pwm peripheral is fitted
module uniboard_top
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic uart_rx,
	output logic uart_tx,
	output logic motor_pwm_l,
	output logic motor_pwm_r
);
	logic [7:0] rx_data;
	logic rx_valid;
	command_t cmd;
	logic cmd_req;
	logic cmd_ack;
	bus_req_t bus_req;
	logic [127:0] select;
	bus_rsp_t pwm_rsp;
	bus_rsp_t bus_rsp;
	reply_t reply;
	logic reply_req;
	logic reply_ack;
	logic [7:0] tx_data;
	logic send;
	logic tx_busy;

	uart_rx u_rx (.clk_12MHz(clk_12MHz), .reset(reset), .rx(uart_rx),
		.data(rx_data), .data_valid(rx_valid));

	frame_decoder u_decoder (.clk_12MHz(clk_12MHz), .reset(reset), .data(rx_data),
		.data_valid(rx_valid), .cmd(cmd), .cmd_req(cmd_req), .cmd_ack(cmd_ack));

	bus_sequencer u_sequencer (.clk_12MHz(clk_12MHz), .reset(reset), .cmd(cmd),
		.cmd_req(cmd_req), .cmd_ack(cmd_ack), .bus_req(bus_req), .select(select),
		.bus_rsp(bus_rsp), .reply(reply), .reply_req(reply_req), .reply_ack(reply_ack));

	reply_encoder u_encoder (.clk_12MHz(clk_12MHz), .reset(reset), .reply(reply),
		.reply_req(reply_req), .reply_ack(reply_ack), .tx_data(tx_data), .send(send),
		.busy(tx_busy));

	uart_tx u_tx (.clk_12MHz(clk_12MHz), .reset(reset), .data(tx_data), .send(send),
		.busy(tx_busy), .tx(uart_tx));

	motor_pwm_peripheral u_motor_pwm (.clk_12MHz(clk_12MHz), .reset(reset),
		.bus_req(bus_req), .select(select[pwm_periph_id]), .bus_rsp(pwm_rsp),
		.pwm_left(motor_pwm_l), .pwm_right(motor_pwm_r));

	// every other select bit lands on the null peripheral, zero data and size
	assign bus_rsp = select[pwm_periph_id] ? pwm_rsp : '0;
endmodule

// File: bench/uniboard_assertions.sv
// duty registers come in through the bind from u_motor_pwm; checks pause while reset is high
module uniboard_assertions
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic uart_tx,
	input logic motor_pwm_l,
	input logic motor_pwm_r,
	input logic [7:0] duty_left,
	input logic [7:0] duty_right
);
	int fail_count;
	// clocks in a row that motor_pwm_r has been low at full duty
	int low_run;

	initial fail_count = 0;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset || motor_pwm_r || duty_right != 8'd255)
			low_run <= 0;
		else
			low_run <= low_run + 1;
	end

	// line idle and motors off right out of reset
	reset_idle: assert property (@(posedge clk_12MHz)
		reset |=> uart_tx && !motor_pwm_l && !motor_pwm_r)
	else
	begin
		$error("uart_tx or a pwm output not idle after reset");
		fail_count++;
	end

	// no write yet, both outputs stay low
	idle_until_write: assert property (@(posedge clk_12MHz) disable iff (reset)
		duty_left == 8'd0 && duty_right == 8'd0 |=> !motor_pwm_l && !motor_pwm_r)
	else
	begin
		$error("pwm output high with both duties at zero");
		fail_count++;
	end

	left_zero_no_rise: assert property (@(posedge clk_12MHz) disable iff (reset)
		duty_left == 8'd0 |=> !$rose(motor_pwm_l))
	else
	begin
		$error("motor_pwm_l rose with left duty at zero");
		fail_count++;
	end

	// count 255 is the only low tick at full duty
	right_full_low_tick: assert property (@(posedge clk_12MHz) disable iff (reset)
		low_run <= pwm_tick_div)
	else
	begin
		$error("motor_pwm_r low for more than one tick at right duty 255");
		fail_count++;
	end
endmodule

bind uniboard_top uniboard_assertions u_assertions (.clk_12MHz(clk_12MHz), .reset(reset),
	.uart_tx(uart_tx), .motor_pwm_l(motor_pwm_l), .motor_pwm_r(motor_pwm_r),
	.duty_left(u_motor_pwm.duty_left), .duty_right(u_motor_pwm.duty_right));

// File: bench/uniboard_tb.sv
// frames go into uart_rx and uart_tx is decoded on the falling edge; replies start within 3600 clocks
module uniboard_tb
	import uniboard_pkg::*;
();
	logic clk_12MHz;
	logic reset;
	logic uart_rx;
	logic uart_tx;
	logic motor_pwm_l;
	logic motor_pwm_r;

	int errors;
	int checks;
	int seed;
	logic got;
	logic [7:0] duty;
	// register contents as the host expects them
	logic [7:0] model_left;
	logic [7:0] model_right;
	logic [7:0] payload_q [$];
	logic [7:0] frame_q [$];
	logic [7:0] expect_q [$];
	logic [7:0] wire_q [$];

	uniboard_top u_dut (.clk_12MHz(clk_12MHz), .reset(reset), .uart_rx(uart_rx),
		.uart_tx(uart_tx), .motor_pwm_l(motor_pwm_l), .motor_pwm_r(motor_pwm_r));

	always #50 clk_12MHz = ~clk_12MHz;

	function automatic logic is_special(input logic [7:0] value);
		return value == byte_start || value == byte_end || value == byte_escape;
	endfunction

	// start, escaped payload, end
	function automatic void build_frame();
		frame_q = {};
		frame_q.push_back(byte_start);
		foreach (payload_q[i])
		begin
			if (is_special(payload_q[i]))
				frame_q.push_back(byte_escape);
			frame_q.push_back(payload_q[i]);
		end
		frame_q.push_back(byte_end);
	endfunction

	// 8n1, lsb first, bits change on the rising edge
	task automatic serial_byte(input logic [7:0] value);
		logic [9:0] bits;
		bits = {1'b1, value, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clk_12MHz);
			uart_rx <= bits[i];
			repeat (clks_per_bit - 1) @(posedge clk_12MHz);
		end
	endtask

	task automatic send_frame_q();
		foreach (frame_q[i])
			serial_byte(frame_q[i]);
	endtask

	// one character off uart_tx; ok stays low without a start bit in time
	task automatic read_char(input int timeout, output logic [7:0] value, output logic ok);
		int waited;
		ok = 1'b0;
		value = '0;
		waited = 0;
		@(negedge clk_12MHz);
		while (uart_tx && waited < timeout)
		begin
			@(negedge clk_12MHz);
			waited++;
		end
		if (uart_tx)
			return;
		// mid start bit, then mid of each data bit
		repeat (clks_per_bit / 2) @(negedge clk_12MHz);
		for (int i = 0; i < 8; i++)
		begin
			repeat (clks_per_bit) @(negedge clk_12MHz);
			value[i] = uart_tx;
		end
		repeat (clks_per_bit) @(negedge clk_12MHz);
		checks++;
		assert (uart_tx) else
		begin
			errors++;
			$display("reply character 0x%02h has a low stop bit", value);
		end
		ok = 1'b1;
	endtask

	// raw wire bytes up to the first unescaped end byte
	task automatic capture_reply(output logic found);
		logic [7:0] value;
		logic ok;
		logic escaped;
		wire_q = {};
		escaped = 1'b0;
		read_char(300 * clks_per_bit, value, ok);
		found = ok;
		if (!ok)
			return;
		wire_q.push_back(value);
		while (wire_q.size() < 16)
		begin
			read_char(4 * clks_per_bit, value, ok);
			if (!ok)
			begin
				errors++;
				$display("timeout waiting for the next reply byte after %0d bytes",
					wire_q.size());
				return;
			end
			wire_q.push_back(value);
			if (!escaped && value == byte_end)
				return;
			escaped = !escaped && value == byte_escape;
		end
	endtask

	task automatic check_reply(input string name, input logic found);
		checks++;
		assert (found) else
		begin
			errors++;
			$display("no reply for test %s before the timeout", name);
		end
		if (!found)
			return;
		checks++;
		assert (wire_q.size() == expect_q.size()) else
		begin
			errors++;
			$display("mismatch %s length expected %0d actual %0d", name,
				expect_q.size(), wire_q.size());
		end
		for (int i = 0; i < expect_q.size() && i < wire_q.size(); i++)
		begin
			checks++;
			assert (wire_q[i] == expect_q[i]) else
			begin
				errors++;
				$display("mismatch %s byte %0d expected 0x%02h actual 0x%02h", name, i,
					expect_q[i], wire_q[i]);
			end
		end
	endtask

	// one write data byte at most, the rest zero filled by the decoder
	task automatic run_command(input string name, input logic read, input logic [6:0] periph,
		input logic [7:0] addr, input logic [7:0] wbyte);
		logic found;
		logic is_pwm;
		is_pwm = periph == 7'(pwm_periph_id);
		if (!read && is_pwm && addr == reg_left_duty)
			model_left = wbyte;
		if (!read && is_pwm && addr == reg_right_duty)
			model_right = wbyte;
		// expected reply echoes the header and adds one data byte for pwm only
		payload_q = {};
		payload_q.push_back({read, periph});
		payload_q.push_back(addr);
		if (is_pwm)
			payload_q.push_back(addr == reg_left_duty ? model_left :
				addr == reg_right_duty ? model_right : 8'h00);
		build_frame();
		expect_q = frame_q;
		payload_q = {};
		payload_q.push_back({read, periph});
		payload_q.push_back(addr);
		if (!read)
			payload_q.push_back(wbyte);
		build_frame();
		fork
			send_frame_q();
			capture_reply(found);
		join
		check_reply(name, found);
		repeat (20) @(posedge clk_12MHz);
	endtask

	initial
	begin
		seed = 15051;
		errors = 0;
		checks = 0;
		model_left = '0;
		model_right = '0;
		clk_12MHz = 1'b0;
		reset <= 1'b1;
		uart_rx <= 1'b1;
		repeat (2) @(posedge clk_12MHz);
		reset <= 1'b0;
		repeat (20) @(posedge clk_12MHz);
		duty = 8'($random(seed));
		run_command("write_left_random", 1'b0, 7'd2, reg_left_duty, duty);
		run_command("read_left", 1'b1, 7'd2, reg_left_duty, 8'h00);
		run_command("read_null", 1'b1, 7'd5, 8'h03, 8'h00);
		run_command("write_null", 1'b0, 7'd5, 8'h03, 8'h5A);
		// special bytes as write data; right duty address 0x01 is special too
		run_command("escape_start", 1'b0, 7'd2, reg_right_duty, byte_start);
		run_command("escape_end", 1'b0, 7'd2, reg_right_duty, byte_end);
		run_command("escape_escape", 1'b0, 7'd2, reg_right_duty, byte_escape);
		run_command("read_right_escaped", 1'b1, 7'd2, reg_right_duty, 8'h00);
		// single payload byte frame is discarded
		frame_q = {byte_start, 8'h82, byte_end};
		fork
			send_frame_q();
			capture_reply(got);
		join
		checks++;
		assert (!got) else
		begin
			errors++;
			$display("the one byte frame was answered instead of discarded");
		end
		// partial read of peripheral 5 cut short by a second start
		payload_q = {};
		payload_q.push_back(8'h82);
		payload_q.push_back(reg_left_duty);
		payload_q.push_back(model_left);
		build_frame();
		expect_q = frame_q;
		frame_q = {byte_start, 8'h85, 8'h00, byte_start, 8'h82, reg_left_duty, byte_end};
		fork
			send_frame_q();
			capture_reply(got);
		join
		check_reply("restart", got);
		// left off while the right runs at full duty
		run_command("write_left_zero", 1'b0, 7'd2, reg_left_duty, 8'h00);
		// full right duty and a whole pwm period for the bound checks
		run_command("write_right_full", 1'b0, 7'd2, reg_right_duty, 8'hFF);
		repeat (257 * pwm_tick_div) @(posedge clk_12MHz);
		$display("checks run %0d, testbench errors %0d, assertion failures %0d", checks,
			errors, u_dut.u_assertions.fail_count);
		if (errors == 0 && u_dut.u_assertions.fail_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end
endmodule

// File: build.f
verilog/uniboard_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/frame_decoder.sv
verilog/bus_sequencer.sv
verilog/reply_encoder.sv
verilog/motor_pwm_peripheral.sv
verilog/uniboard_top.sv
bench/uniboard_assertions.sv
bench/uniboard_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = uniboard_tb
FILELIST = build.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
